// File: Bender.yml
package:
  name: daq_subsystem

sources:
  - hdl/DaqTypesPkg.sv
  - hdl/AsicTimingPkg.sv
  - hdl/EdgeSync.sv
  - hdl/SlaveDaq.sv
  - hdl/TriggerCounter.sv
  - hdl/DaqDataMux.sv
  - hdl/DaqSubsystem.sv
  - target: simulation
    files:
      - verification/MicrorocModel.sv
      - verification/DaqSubsystemTb.sv

// File: DaqSubsystem.f
hdl/DaqTypesPkg.sv
hdl/AsicTimingPkg.sv
hdl/EdgeSync.sv
hdl/SlaveDaq.sv
hdl/TriggerCounter.sv
hdl/DaqDataMux.sv
hdl/DaqSubsystem.sv
verification/MicrorocModel.sv
verification/DaqSubsystemTb.sv

// File: hdl/AsicTimingPkg.sv
package AsicTimingPkg;

    ////////////////////
    // Chip timing, in Clk cycles
    ////////////////////

    // Clock LVDS receivers wake-up while ResetB is held low
    localparam int unsigned TimeMinPowerReset = 8;

    // Internal management after reset release, slow and fast clock ticks
    localparam int unsigned TimeMinResetStart = 40;

    // Minimum width of the readout start pulse
    localparam int unsigned TimeMinSro = 16;

    ////////////////////
    // Run tail words
    ////////////////////
    localparam logic [15:0] TailMarkWord  = 16'hFF45;  // First word after stop
    localparam logic [7:0]  CountHiPrefix = 8'hCC;     // Tags the high count byte

endpackage

// File: hdl/DaqDataMux.sv
`timescale 1ns/1ps

module DaqDataMux (
    input  DaqTypesPkg::TailSel   TailSelect,
    input  logic                  TailValid,
    input  DaqTypesPkg::TrigCount TrigCountValue,
    input  DaqTypesPkg::DaqWord   MicrorocData,
    input  logic                  MicrorocDataEn,
    output DaqTypesPkg::DaqWord   SlaveDaqData,
    output logic                  SlaveDaqDataEn
);

    import DaqTypesPkg::*;
    import AsicTimingPkg::*;

    ////////////////////
    // Output word select
    ////////////////////
    always_comb begin
        case (TailSelect)
            TAIL_MARK: begin
                SlaveDaqData   = TailMarkWord;
                SlaveDaqDataEn = TailValid;
            end
            TAIL_COUNT_HI: begin
                SlaveDaqData   = {CountHiPrefix, TrigCountValue[23:16]};
                SlaveDaqDataEn = TailValid;
            end
            TAIL_COUNT_LO: begin
                SlaveDaqData   = TrigCountValue[15:0];
                SlaveDaqDataEn = TailValid;
            end
            default: begin  // Normal readout, chip stream straight through
                SlaveDaqData   = MicrorocData;
                SlaveDaqDataEn = MicrorocDataEn;
            end
        endcase
    end

endmodule

// File: hdl/DaqSubsystem.sv
`timescale 1ns/1ps

module DaqSubsystem (
    input  logic                   Clk,
    input  logic                   reset_n,
    input  logic                   ModuleStart,
    input  logic                   AcqStart,
    input  logic                   ChipSatB,
    input  logic                   EndReadout,
    input  DaqTypesPkg::DelayCount AcquisitionTime,
    input  DaqTypesPkg::DelayCount EndHoldTime,
    input  DaqTypesPkg::DaqWord    MicrorocData,
    input  logic                   MicrorocDataEn,
    input  logic                   DataTransmitDone,
    output logic                   ResetB,
    output logic                   StartAcq,
    output logic                   ForceExternalRaz,
    output logic                   StartReadout,
    output logic                   PwrOnA,
    output logic                   PwrOnD,
    output logic                   PwrOnDac,
    output logic                   OnceEnd,
    output logic                   AllDone,
    output DaqTypesPkg::DaqWord    SlaveDaqData,
    output logic                   SlaveDaqDataEn
);

    import DaqTypesPkg::*;

    logic     trigRise;
    logic     satFall;
    logic     satRise;
    logic     endReadoutSync;
    logic     trigCountEn;
    logic     trigCountClr;
    TrigCount trigCountValue;
    TailSel   tailSelect;
    logic     tailValid;

    ////////////////////
    // Input synchronizers
    ////////////////////
    EdgeSync #(.ResetLevel(1'b0)) u_trigSync (
        .Clk(Clk), .reset_n(reset_n), .AsyncIn(AcqStart),
        .Level(), .Rise(trigRise), .Fall()
    );

    EdgeSync #(.ResetLevel(1'b1)) u_satSync (  // Active-low line idles high
        .Clk(Clk), .reset_n(reset_n), .AsyncIn(ChipSatB),
        .Level(), .Rise(satRise), .Fall(satFall)
    );

    EdgeSync #(.ResetLevel(1'b0)) u_endReadSync (
        .Clk(Clk), .reset_n(reset_n), .AsyncIn(EndReadout),
        .Level(endReadoutSync), .Rise(), .Fall()
    );

    ////////////////////
    // Sequencer, counter and output word
    ////////////////////
    SlaveDaq u_slaveDaq (
        .Clk(Clk), .reset_n(reset_n), .ModuleStart(ModuleStart),
        .TrigRise(trigRise), .SatFall(satFall), .SatRise(satRise),
        .EndReadoutSync(endReadoutSync), .AcquisitionTime(AcquisitionTime),
        .EndHoldTime(EndHoldTime), .DataTransmitDone(DataTransmitDone),
        .ResetB(ResetB), .StartAcq(StartAcq), .ForceExternalRaz(ForceExternalRaz),
        .StartReadout(StartReadout), .PwrOnA(PwrOnA), .PwrOnD(PwrOnD),
        .PwrOnDac(PwrOnDac), .OnceEnd(OnceEnd), .AllDone(AllDone),
        .TrigCountEn(trigCountEn), .TrigCountClr(trigCountClr),
        .TailSelect(tailSelect), .TailValid(tailValid)
    );

    TriggerCounter u_trigCounter (
        .Clk(Clk), .reset_n(reset_n), .TrigRise(trigRise),
        .TrigCountEn(trigCountEn), .TrigCountClr(trigCountClr),
        .TrigCountValue(trigCountValue)
    );

    DaqDataMux u_dataMux (
        .TailSelect(tailSelect), .TailValid(tailValid),
        .TrigCountValue(trigCountValue), .MicrorocData(MicrorocData),
        .MicrorocDataEn(MicrorocDataEn), .SlaveDaqData(SlaveDaqData),
        .SlaveDaqDataEn(SlaveDaqDataEn)
    );

endmodule

// File: hdl/DaqTypesPkg.sv
package DaqTypesPkg;

    ////////////////////
    // Data path widths
    ////////////////////
    typedef logic [15:0] DaqWord;     // ASIC data and output word
    typedef logic [23:0] TrigCount;   // Triggers seen over one run
    typedef logic [15:0] DelayCount;  // Shared timer and programmed times

    // Sequencer states, in the order the chip walks through them
    typedef enum logic [3:0] {
        IDLE              = 4'd0,
        CHIP_RESET        = 4'd1,
        POWER_ON          = 4'd2,
        RELEASE           = 4'd3,
        WAIT_START        = 4'd4,
        START_ACQUISITION = 4'd5,
        WAIT_READ         = 4'd6,
        START_READOUT     = 4'd7,
        WAIT_READ_DONE    = 4'd8,
        ONCE_END          = 4'd9,
        OUT_TAIL          = 4'd10,
        OUT_COUNT_HI      = 4'd11,
        OUT_COUNT_LO      = 4'd12,
        ALL_DONE          = 4'd13
    } DaqState;

    // Which tail word goes out in place of the ASIC stream
    typedef enum logic [1:0] {
        TAIL_NONE, TAIL_MARK, TAIL_COUNT_HI, TAIL_COUNT_LO
    } TailSel;

endpackage

// File: hdl/EdgeSync.sv
`timescale 1ns/1ps

module EdgeSync #(
    parameter bit ResetLevel = 1'b0  // Idle level of the line
) (
    input  logic Clk,
    input  logic reset_n,
    input  logic AsyncIn,
    output logic Level,
    output logic Rise,
    output logic Fall
);

    logic syncQ1;  // Metastability stage
    logic syncQ2;  // Previous sample

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            syncQ1 <= ResetLevel;
            syncQ2 <= ResetLevel;
        end else begin
            syncQ1 <= AsyncIn;
            syncQ2 <= syncQ1;
        end
    end

    // One-cycle pulses on a change between the two stages
    assign Rise  = syncQ1 & ~syncQ2;
    assign Fall  = ~syncQ1 & syncQ2;
    assign Level = syncQ2;

endmodule

// File: hdl/SlaveDaq.sv
`timescale 1ns/1ps

module SlaveDaq (
    input  logic                   Clk,
    input  logic                   reset_n,
    input  logic                   ModuleStart,
    input  logic                   TrigRise,        // Synchronized trigger edge
    input  logic                   SatFall,         // Chip memory full
    input  logic                   SatRise,         // Readout may start
    input  logic                   EndReadoutSync,
    input  DaqTypesPkg::DelayCount AcquisitionTime,
    input  DaqTypesPkg::DelayCount EndHoldTime,
    input  logic                   DataTransmitDone,
    output logic                   ResetB,
    output logic                   StartAcq,
    output logic                   ForceExternalRaz,
    output logic                   StartReadout,
    output logic                   PwrOnA,
    output logic                   PwrOnD,
    output logic                   PwrOnDac,
    output logic                   OnceEnd,
    output logic                   AllDone,
    output logic                   TrigCountEn,
    output logic                   TrigCountClr,
    output DaqTypesPkg::TailSel    TailSelect,
    output logic                   TailValid
);

    import DaqTypesPkg::*;
    import AsicTimingPkg::*;

    DaqState   state;
    DelayCount delayCnt;  // Shared by every timed state

    ////////////////////
    // Sequencer
    ////////////////////
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            state            <= IDLE;
            delayCnt         <= '0;
            ResetB           <= 1'b1;
            StartAcq         <= 1'b0;
            ForceExternalRaz <= 1'b1;
            StartReadout     <= 1'b0;
            OnceEnd          <= 1'b0;
            AllDone          <= 1'b0;
            TrigCountEn      <= 1'b0;
            TrigCountClr     <= 1'b0;
            TailValid        <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (ModuleStart) begin
                        ResetB       <= 1'b0;
                        TrigCountClr <= 1'b1;  // Held until the chip is released
                        state        <= CHIP_RESET;
                    end
                end
                CHIP_RESET: begin
                    state <= POWER_ON;
                end
                POWER_ON: begin
                    if (delayCnt < TimeMinPowerReset) begin
                        delayCnt <= delayCnt + 16'd1;
                    end else begin
                        delayCnt <= '0;
                        ResetB   <= 1'b1;
                        state    <= RELEASE;
                    end
                end
                RELEASE: begin
                    if (delayCnt < TimeMinResetStart) begin
                        delayCnt <= delayCnt + 16'd1;
                    end else begin
                        delayCnt     <= '0;
                        TrigCountClr <= 1'b0;
                        TrigCountEn  <= 1'b1;
                        state        <= WAIT_START;
                    end
                end
                WAIT_START: begin
                    if (!ModuleStart) begin  // Run stopped, send the tail
                        TrigCountEn <= 1'b0;
                        state       <= OUT_TAIL;
                    end else if (TrigRise) begin
                        StartAcq         <= 1'b1;
                        ForceExternalRaz <= 1'b0;
                        state            <= START_ACQUISITION;
                    end
                end
                START_ACQUISITION: begin
                    // Window ends on timeout or when the chip fills up
                    if (delayCnt >= AcquisitionTime || SatFall) begin
                        delayCnt         <= '0;
                        StartAcq         <= 1'b0;
                        ForceExternalRaz <= 1'b1;
                        state            <= WAIT_READ;
                    end else begin
                        delayCnt <= delayCnt + 16'd1;
                    end
                end
                WAIT_READ: begin
                    if (SatRise) begin
                        StartReadout <= 1'b1;
                        state        <= START_READOUT;
                    end
                end
                START_READOUT: begin
                    if (delayCnt < TimeMinSro) begin
                        delayCnt <= delayCnt + 16'd1;
                    end else begin
                        delayCnt     <= '0;
                        StartReadout <= 1'b0;
                        state        <= WAIT_READ_DONE;
                    end
                end
                WAIT_READ_DONE: begin
                    if (EndReadoutSync) begin
                        OnceEnd <= 1'b1;
                        state   <= ONCE_END;
                    end
                end
                ONCE_END: begin
                    if (delayCnt < EndHoldTime) begin
                        delayCnt <= delayCnt + 16'd1;
                    end else begin
                        delayCnt <= '0;
                        OnceEnd  <= 1'b0;
                        state    <= WAIT_START;  // Ready for the next trigger
                    end
                end
                OUT_TAIL, OUT_COUNT_HI, OUT_COUNT_LO: begin
                    // Two cycles per word, strobe in the second one
                    if (delayCnt == 16'd0) begin
                        delayCnt  <= 16'd1;
                        TailValid <= 1'b1;
                    end else begin
                        delayCnt  <= '0;
                        TailValid <= 1'b0;
                        case (state)
                            OUT_TAIL:     state <= OUT_COUNT_HI;
                            OUT_COUNT_HI: state <= OUT_COUNT_LO;
                            default: begin
                                AllDone <= 1'b1;
                                state   <= ALL_DONE;
                            end
                        endcase
                    end
                end
                ALL_DONE: begin
                    if (DataTransmitDone) begin
                        AllDone <= 1'b0;
                        state   <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    ////////////////////
    // Power pulsing and tail word decode
    ////////////////////
    always_comb begin
        PwrOnA = state inside {CHIP_RESET, POWER_ON, RELEASE, WAIT_START,
                               START_ACQUISITION, WAIT_READ, START_READOUT,
                               WAIT_READ_DONE, ONCE_END};
        PwrOnDac = PwrOnA;
        PwrOnD   = PwrOnA && (state != CHIP_RESET);  // Digital part one cycle later
    end

    always_comb begin
        case (state)
            OUT_TAIL:     TailSelect = TAIL_MARK;
            OUT_COUNT_HI: TailSelect = TAIL_COUNT_HI;
            OUT_COUNT_LO: TailSelect = TAIL_COUNT_LO;
            default:      TailSelect = TAIL_NONE;
        endcase
    end

    // The chip must never be acquiring while idle, powering up or in the tail
    StartAcqOnlyInWindow: assert property (@(posedge Clk) disable iff (!reset_n)
        StartAcq |-> (state inside {START_ACQUISITION, WAIT_READ, START_READOUT,
                                    WAIT_READ_DONE}))
        else $error("Error %0t StartAcq high in state %s", $time, state.name());

    TailStrobeHasWord: assert property (@(posedge Clk) disable iff (!reset_n)
        TailValid |-> (TailSelect != TAIL_NONE))
        else $error("Error %0t TailValid without a tail word", $time);

endmodule

// File: hdl/TriggerCounter.sv
`timescale 1ns/1ps

module TriggerCounter (
    input  logic                  Clk,
    input  logic                  reset_n,
    input  logic                  TrigRise,
    input  logic                  TrigCountEn,
    input  logic                  TrigCountClr,
    output DaqTypesPkg::TrigCount TrigCountValue
);

    ////////////////////
    // Trigger count
    ////////////////////
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            TrigCountValue <= '0;
        end else if (TrigCountClr) begin  // Clear wins over counting
            TrigCountValue <= '0;
        end else if (TrigCountEn && TrigRise) begin
            TrigCountValue <= TrigCountValue + 24'd1;
        end
    end

    // The tail reports a frozen count once the run has stopped
    CountFrozenWhenOff: assert property (@(posedge Clk) disable iff (!reset_n)
        (!TrigCountEn && !TrigCountClr) |=> (TrigCountValue == $past(TrigCountValue)))
        else $error("Error %0t TrigCountValue expected %0d actual %0d", $time,
                    $past(TrigCountValue), TrigCountValue);

endmodule

// File: verification/DaqSubsystemTb.sv
`timescale 1ns/1ps

module DaqSubsystemTb;

    import DaqTypesPkg::*;

    localparam int HoldTime      = 12;
    localparam int TimeoutCycles = 4 * (60 + 300 + 200) + 2000;

    logic Clk, reset_n, ModuleStart, AcqStart, ChipSatB, EndReadout, UseSat;
    logic MicrorocDataEn, DataTransmitDone, SlaveDaqDataEn;
    logic ResetB, StartAcq, ForceExternalRaz, StartReadout, PwrOnA, PwrOnD, PwrOnDac;
    logic OnceEnd, AllDone;
    DelayCount AcquisitionTime, EndHoldTime;
    DaqWord    MicrorocData, SlaveDaqData;
    TrigCount  expCount;   // Triggers driven in the current run
    DaqState   seqState;
    int errCnt, cycleCnt, acqLen, tailWords;
    integer seed;

    DaqSubsystem u_dut (.*);
    MicrorocModel u_asic (.*);

    assign seqState = u_dut.u_slaveDaq.state;

    initial begin
        Clk = 1'b0;
        forever #4 Clk = ~Clk;
    end

    always @(posedge Clk) begin
        cycleCnt <= cycleCnt + 1;
        acqLen   <= StartAcq ? acqLen + 1 : 0;
        if (seqState == IDLE) begin
            tailWords <= 0;
        end else if (SlaveDaqDataEn &&
                     seqState inside {OUT_TAIL, OUT_COUNT_HI, OUT_COUNT_LO}) begin
            tailWords <= tailWords + 1;
        end
        if (cycleCnt >= TimeoutCycles) begin
            $display("Timeout after %0d cycles, sequencer stuck in %s", cycleCnt,
                     seqState.name());
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic countError(input string msg);
        errCnt++;
        $display("%s", msg);
    endtask

    ////////////////////
    // Checks
    ////////////////////
    aResetStart: assert property (@(posedge Clk) disable iff (!reset_n)
        $rose(ModuleStart) |=> $fell(ResetB))
        else countError($sformatf("ResetB did not fall after ModuleStart at %0t", $time));
    aResetLen: assert property (@(posedge Clk) disable iff (!reset_n)
        $fell(ResetB) |=> !ResetB [*9] ##1 ResetB)
        else countError($sformatf("ResetB low period is not 10 cycles at %0t", $time));
    aPowerUp: assert property (@(posedge Clk) disable iff (!reset_n)
        $fell(ResetB) |-> PwrOnA && PwrOnDac && !PwrOnD ##1 PwrOnD)
        else countError($sformatf("Power-up order wrong at %0t", $time));
    aPowerHeld: assert property (@(posedge Clk) disable iff (!reset_n)
        (StartAcq || StartReadout || OnceEnd) |-> PwrOnA && PwrOnD && PwrOnDac)
        else countError($sformatf("Power off during acquisition at %0t", $time));
    aPowerTail: assert property (@(posedge Clk) disable iff (!reset_n)
        AllDone |-> !PwrOnA && !PwrOnD && !PwrOnDac)
        else countError($sformatf("Power still on in the tail at %0t", $time));

    // Window opens on a trigger edge and closes on time or chip full
    aAcqTrig: assert property (@(posedge Clk) disable iff (!reset_n)
        $rose(StartAcq) |-> $past(AcqStart, 2) && !$past(AcqStart, 3))
        else countError($sformatf("StartAcq rose without an AcqStart edge at %0t", $time));
    aAcqLen: assert property (@(posedge Clk) disable iff (!reset_n)
        StartAcq |-> acqLen <= AcquisitionTime)
        else countError($sformatf("Error %0t acqLen expected <= %0d actual %0d", $time,
                                  $sampled(AcquisitionTime), $sampled(acqLen)));
    aAcqSat: assert property (@(posedge Clk) disable iff (!reset_n)
        $fell(ChipSatB) && StartAcq |-> ##[0:3] !StartAcq)
        else countError($sformatf("Window not closed after chip full at %0t", $time));
    aRaz: assert property (@(posedge Clk) disable iff (!reset_n)
        ForceExternalRaz == !StartAcq)
        else countError($sformatf("Error %0t ForceExternalRaz expected %b actual %b", $time,
                                  !$sampled(StartAcq), $sampled(ForceExternalRaz)));

    aSroStart: assert property (@(posedge Clk) disable iff (!reset_n)
        $rose(StartReadout) |-> $past(ChipSatB, 2) && !$past(ChipSatB, 3))
        else countError($sformatf("StartReadout rose without ChipSatB rising at %0t", $time));
    aSroLen: assert property (@(posedge Clk) disable iff (!reset_n)
        $rose(StartReadout) |-> StartReadout [*17] ##1 !StartReadout)
        else countError($sformatf("StartReadout is not 17 cycles at %0t", $time));
    aHoldLen: assert property (@(posedge Clk) disable iff (!reset_n)
        $rose(OnceEnd) |-> OnceEnd [*HoldTime + 1] ##1 !OnceEnd)
        else countError($sformatf("OnceEnd is not %0d cycles at %0t", HoldTime + 1, $time));

    // Chip stream passes straight through outside the tail
    aDataPass: assert property (@(posedge Clk) disable iff (!reset_n)
        !(seqState inside {OUT_TAIL, OUT_COUNT_HI, OUT_COUNT_LO}) |->
        SlaveDaqData == MicrorocData)
        else countError($sformatf("Error %0t SlaveDaqData expected %h actual %h", $time,
                                  $sampled(MicrorocData), $sampled(SlaveDaqData)));
    aStrobePass: assert property (@(posedge Clk) disable iff (!reset_n)
        !(seqState inside {OUT_TAIL, OUT_COUNT_HI, OUT_COUNT_LO}) |->
        SlaveDaqDataEn == MicrorocDataEn)
        else countError($sformatf("Error %0t SlaveDaqDataEn expected %b actual %b", $time,
                                  $sampled(MicrorocDataEn), $sampled(SlaveDaqDataEn)));

    aTailMark: assert property (@(posedge Clk) disable iff (!reset_n)
        SlaveDaqDataEn && seqState == OUT_TAIL |-> SlaveDaqData == 16'hFF45)
        else countError($sformatf("Error %0t SlaveDaqData expected ff45 actual %h", $time,
                                  $sampled(SlaveDaqData)));
    aTailHi: assert property (@(posedge Clk) disable iff (!reset_n)
        SlaveDaqDataEn && seqState == OUT_COUNT_HI |->
        SlaveDaqData == {8'hCC, expCount[23:16]})
        else countError($sformatf("Error %0t SlaveDaqData expected %h actual %h", $time,
                                  {8'hCC, expCount[23:16]}, $sampled(SlaveDaqData)));
    aTailLo: assert property (@(posedge Clk) disable iff (!reset_n)
        SlaveDaqDataEn && seqState == OUT_COUNT_LO |-> SlaveDaqData == expCount[15:0])
        else countError($sformatf("Error %0t SlaveDaqData expected %h actual %h", $time,
                                  expCount[15:0], $sampled(SlaveDaqData)));
    aTailCount: assert property (@(posedge Clk) disable iff (!reset_n)
        $rose(AllDone) |-> tailWords == 3)
        else countError($sformatf("Error %0t tailWords expected 3 actual %0d", $time,
                                  $sampled(tailWords)));
    aDoneHeld: assert property (@(posedge Clk) disable iff (!reset_n)
        AllDone && !DataTransmitDone |=> AllDone)
        else countError($sformatf("AllDone dropped before DataTransmitDone at %0t", $time));
    aDoneClear: assert property (@(posedge Clk) disable iff (!reset_n)
        $fell(AllDone) |-> $past(DataTransmitDone))
        else countError($sformatf("AllDone fell without DataTransmitDone at %0t", $time));

    ////////////////////
    // Stimulus
    ////////////////////
    task automatic waitState(input DaqState target);
        do @(posedge Clk); while (seqState != target);
    endtask

    task automatic runOnce();
        @(posedge Clk);
        #1;
        AcquisitionTime = 16'd20 + 16'($unsigned($random(seed)) % 41);
        expCount        = '0;
        ModuleStart     = 1'b1;
        waitState(WAIT_START);
        for (int t = 0; t < 2; t++) begin
            repeat (5 + $unsigned($random(seed)) % 20) @(posedge Clk);
            #1;
            UseSat   = (t == 1);
            AcqStart = 1'b1;
            expCount = expCount + 24'd1;
            repeat (3) @(posedge Clk);
            #1 AcqStart = 1'b0;
            waitState(ONCE_END);
            waitState(WAIT_START);
        end
        #1 ModuleStart = 1'b0;
        do @(posedge Clk); while (!AllDone);
        repeat (4) @(posedge Clk);
        #1 DataTransmitDone = 1'b1;
        @(posedge Clk);
        #1 DataTransmitDone = 1'b0;
        waitState(IDLE);
    endtask

    initial begin
        seed = 32'hfb9d;
        errCnt = 0;
        cycleCnt = 0;
        acqLen = 0;
        tailWords = 0;
        reset_n = 1'b0;
        ModuleStart = 1'b0;
        AcqStart = 1'b0;
        UseSat = 1'b0;
        DataTransmitDone = 1'b0;
        AcquisitionTime = 16'd40;
        EndHoldTime = 16'(HoldTime);
        expCount = '0;
        repeat (5) @(posedge Clk);
        #1 reset_n = 1'b1;
        runOnce();
        runOnce();  // Count must restart from zero
        repeat (5) @(posedge Clk);
        $display("Errors: %0d, cycles: %0d", errCnt, cycleCnt);
        if (errCnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: verification/MicrorocModel.sv
`timescale 1ns/1ps

module MicrorocModel (
    input  logic                Clk,
    input  logic                StartAcq,
    input  logic                StartReadout,
    input  logic                UseSat,        // Fill the memory inside the window
    output logic                ChipSatB,
    output logic                EndReadout,
    output DaqTypesPkg::DaqWord MicrorocData,
    output logic                MicrorocDataEn
);

    import DaqTypesPkg::*;

    localparam int SatDelay = 6;   // Cycles from window start to memory full
    localparam int BurstLen = 8;   // Words per readout

    DaqWord wordCnt;

    initial begin
        ChipSatB       = 1'b1;
        EndReadout     = 1'b0;
        MicrorocData   = '0;
        MicrorocDataEn = 1'b0;
        wordCnt        = '0;
        forever begin
            do @(posedge Clk); while (!StartAcq);
            if (UseSat) begin
                repeat (SatDelay) @(posedge Clk);
                #1 ChipSatB = 1'b0;
            end
            do @(posedge Clk); while (StartAcq);
            if (ChipSatB) begin  // Window timed out, report full afterwards
                #1 ChipSatB = 1'b0;
                repeat (2) @(posedge Clk);
            end
            #1 ChipSatB = 1'b1;
            do @(posedge Clk); while (!StartReadout);
            repeat (BurstLen) begin
                @(posedge Clk);
                #1;
                MicrorocData   = wordCnt;
                MicrorocDataEn = 1'b1;
                wordCnt        = wordCnt + 16'd1;
            end
            @(posedge Clk);
            #1 MicrorocDataEn = 1'b0;
            do @(posedge Clk); while (StartReadout);  // Readout ends after the start pulse
            #1 EndReadout = 1'b1;
            repeat (3) @(posedge Clk);
            #1 EndReadout = 1'b0;
        end
    end

endmodule
